/* logic/cachePkg.sv */
package cachePkg;

  // Cache geometry, shared by both caches
  localparam int wordsPerLine = 4;
  localparam int numLines     = 16;

  // Address split below the byte offset
  localparam int offsetBits = $clog2(wordsPerLine);
  localparam int indexBits  = $clog2(numLines);
  localparam int tagBits    = 32 - indexBits - offsetBits - 2;

  // Control register bit positions
  localparam int icacheEnableBit = 12;
  localparam int dcacheEnableBit = 2;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byteMask;
  } cpuReqT;

  typedef struct packed {
    logic [31:0] rdata;
    logic        stall;
  } cpuRspT;

  typedef enum logic [1:0] {
    cpControl,
    cpInvalidateI,
    cpInvalidateD,
    cpInvalidateAll
  } cpOpT;

endpackage

/* logic/busPkg.sv */
package busPkg;

  // Wishbone classic, master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
  } wbMasterT;

  // Wishbone classic, slave to master
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wbSlaveT;

  // Who owns the external bus
  typedef enum logic [1:0] {
    arbIdle,
    arbData,
    arbInstr
  } arbStateT;

endpackage

/* logic/cacheControl.sv */
`timescale 1ns/1ps

module cacheControl (
  input  logic               clk,
  input  logic               rstN,
  input  logic               cpEn,
  input  logic               cpWrite,
  input  cachePkg::cpOpT     cpOp,
  input  logic [31:0]        cpWdata,
  output logic [31:0]        cpRdata,
  output logic               icacheEnable,
  output logic               dcacheEnable,
  output logic               invalidateI,
  output logic               invalidateD
);

  logic [31:0] controlReg;
  logic        opWrite;

  assign opWrite = cpEn && cpWrite;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      controlReg <= '0;
    end
    else if (opWrite && (cpOp == cachePkg::cpControl))
    begin
      controlReg <= cpWdata;
    end
  end

  // Invalidates last exactly as long as the coprocessor strobe
  always_comb
  begin
    invalidateI = 1'b0;
    invalidateD = 1'b0;
    if (opWrite)
    begin
      case (cpOp)
        cachePkg::cpInvalidateI:   invalidateI = 1'b1;
        cachePkg::cpInvalidateD:   invalidateD = 1'b1;
        cachePkg::cpInvalidateAll:
        begin
          invalidateI = 1'b1;
          invalidateD = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign cpRdata      = controlReg;
  assign icacheEnable = controlReg[cachePkg::icacheEnableBit];
  assign dcacheEnable = controlReg[cachePkg::dcacheEnableBit];

endmodule

/* logic/instrCache.sv */
`timescale 1ns/1ps

module instrCache (
  input  logic             clk,
  input  logic             rstN,
  input  logic             enable,
  input  logic             invalidate,
  input  cachePkg::cpuReqT req,
  output cachePkg::cpuRspT rsp,
  output busPkg::wbMasterT wbOut,
  input  busPkg::wbSlaveT  wbIn
);

  typedef enum logic [1:0] {
    icIdle,
    icFill,
    icUncached
  } icStateT;

  icStateT state;

  logic [cachePkg::tagBits-1:0]    tagArr [cachePkg::numLines];
  logic [31:0]                     dataArr [cachePkg::numLines*cachePkg::wordsPerLine];
  logic [cachePkg::numLines-1:0]   validArr;
  logic [cachePkg::offsetBits-1:0] wordCnt;
  logic [31:0]                     bypassData;
  logic                            doneFlag;

  logic [cachePkg::tagBits-1:0]    reqTag;
  logic [cachePkg::indexBits-1:0]  reqIndex;
  logic [cachePkg::offsetBits-1:0] reqWord;
  logic                            hit;
  logic                            missStart;

  assign reqWord  = req.addr[cachePkg::offsetBits+1:2];
  assign reqIndex =
    req.addr[cachePkg::indexBits+cachePkg::offsetBits+1 : cachePkg::offsetBits+2];
  assign reqTag   = req.addr[31 : 32-cachePkg::tagBits];

  assign hit       = enable && validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign missStart = (state == icIdle) && req.valid && !hit && !doneFlag;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= icIdle;
      wordCnt  <= '0;
      validArr <= '0;
      doneFlag <= 1'b0;
    end
    else
    begin
      doneFlag <= 1'b0;
      case (state)
        icIdle:
          if (missStart)
          begin
            wordCnt <= '0;
            if (enable)
            begin
              validArr[reqIndex] <= 1'b0;
              state              <= icFill;
            end
            else
            begin
              state <= icUncached;
            end
          end
        icFill:
          if (wbIn.ack)
          begin
            wordCnt <= wordCnt + 1'b1;
            // All ones means the last word of the line
            if (&wordCnt)
            begin
              validArr[reqIndex] <= 1'b1;
              state              <= icIdle;
            end
          end
        icUncached:
          if (wbIn.ack)
          begin
            doneFlag <= 1'b1;
            state    <= icIdle;
          end
        default: state <= icIdle;
      endcase
      if (invalidate)
      begin
        validArr <= '0;
      end
    end
  end

  // Arrays and bypass word
  always_ff @(posedge clk)
  begin
    if ((state == icFill) && wbIn.ack)
    begin
      dataArr[{reqIndex, wordCnt}] <= wbIn.dat;
      tagArr[reqIndex]             <= reqTag;
    end
    if ((state == icUncached) && wbIn.ack)
    begin
      bypassData <= wbIn.dat;
    end
  end

  always_comb
  begin
    wbOut = '0;
    case (state)
      icFill:
      begin
        wbOut.cyc = 1'b1;
        wbOut.stb = 1'b1;
        wbOut.adr = {req.addr[31:cachePkg::offsetBits+2], wordCnt, 2'b00};
        wbOut.sel = 4'hf;
      end
      icUncached:
      begin
        wbOut.cyc = 1'b1;
        wbOut.stb = 1'b1;
        wbOut.adr = {req.addr[31:2], 2'b00};
        wbOut.sel = 4'hf;
      end
      default: ;
    endcase
  end

  assign rsp.stall = (state != icIdle) || missStart;
  assign rsp.rdata = doneFlag ? bypassData : dataArr[{reqIndex, reqWord}];

endmodule

/* logic/dataCache.sv */
`timescale 1ns/1ps

module dataCache (
  input  logic             clk,
  input  logic             rstN,
  input  logic             enable,
  input  logic             invalidate,
  input  cachePkg::cpuReqT req,
  output cachePkg::cpuRspT rsp,
  output busPkg::wbMasterT wbOut,
  input  busPkg::wbSlaveT  wbIn
);

  typedef enum logic [1:0] {
    dcIdle,
    dcFill,
    dcRead,
    dcWrite
  } dcStateT;

  dcStateT state;

  logic [cachePkg::tagBits-1:0]    tagArr [cachePkg::numLines];
  logic [31:0]                     dataArr [cachePkg::numLines*cachePkg::wordsPerLine];
  logic [cachePkg::numLines-1:0]   validArr;
  logic [cachePkg::offsetBits-1:0] wordCnt;
  logic [31:0]                     bypassData;
  logic                            doneFlag;

  logic [cachePkg::tagBits-1:0]    reqTag;
  logic [cachePkg::indexBits-1:0]  reqIndex;
  logic [cachePkg::offsetBits-1:0] reqWord;
  logic                            lineMatch;
  logic                            hit;
  logic                            accessStart;

  assign reqWord  = req.addr[cachePkg::offsetBits+1:2];
  assign reqIndex =
    req.addr[cachePkg::indexBits+cachePkg::offsetBits+1 : cachePkg::offsetBits+2];
  assign reqTag   = req.addr[31 : 32-cachePkg::tagBits];

  // Line present, whether or not the cache is enabled
  assign lineMatch = validArr[reqIndex] && (tagArr[reqIndex] == reqTag);
  assign hit       = enable && lineMatch;

  // Stores always go to the bus, loads only on a miss
  assign accessStart = (state == dcIdle) && req.valid && !doneFlag && (req.write || !hit);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      state    <= dcIdle;
      wordCnt  <= '0;
      validArr <= '0;
      doneFlag <= 1'b0;
    end
    else
    begin
      doneFlag <= 1'b0;
      case (state)
        dcIdle:
          if (accessStart)
          begin
            wordCnt <= '0;
            if (req.write)
            begin
              state <= dcWrite;
            end
            else if (enable)
            begin
              validArr[reqIndex] <= 1'b0;
              state              <= dcFill;
            end
            else
            begin
              state <= dcRead;
            end
          end
        dcFill:
          if (wbIn.ack)
          begin
            wordCnt <= wordCnt + 1'b1;
            if (&wordCnt)
            begin
              validArr[reqIndex] <= 1'b1;
              state              <= dcIdle;
            end
          end
        dcRead, dcWrite:
          if (wbIn.ack)
          begin
            doneFlag <= 1'b1;
            state    <= dcIdle;
          end
        default: state <= dcIdle;
      endcase
      if (invalidate)
      begin
        validArr <= '0;
      end
    end
  end

  // Fill words, store merge and the bypass word
  always_ff @(posedge clk)
  begin
    if ((state == dcFill) && wbIn.ack)
    begin
      dataArr[{reqIndex, wordCnt}] <= wbIn.dat;
      tagArr[reqIndex]             <= reqTag;
    end
    if ((state == dcWrite) && wbIn.ack && lineMatch)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (req.byteMask[b])
        begin
          dataArr[{reqIndex, reqWord}][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
    if ((state == dcRead) && wbIn.ack)
    begin
      bypassData <= wbIn.dat;
    end
  end

  always_comb
  begin
    wbOut = '0;
    case (state)
      dcFill:
      begin
        wbOut.cyc = 1'b1;
        wbOut.stb = 1'b1;
        wbOut.adr = {req.addr[31:cachePkg::offsetBits+2], wordCnt, 2'b00};
        wbOut.sel = 4'hf;
      end
      dcRead:
      begin
        wbOut.cyc = 1'b1;
        wbOut.stb = 1'b1;
        wbOut.adr = {req.addr[31:2], 2'b00};
        wbOut.sel = 4'hf;
      end
      dcWrite:
      begin
        wbOut.cyc = 1'b1;
        wbOut.stb = 1'b1;
        wbOut.we  = 1'b1;
        wbOut.adr = {req.addr[31:2], 2'b00};
        wbOut.dat = req.wdata;
        wbOut.sel = req.byteMask;
      end
      default: ;
    endcase
  end

  assign rsp.stall = (state != dcIdle) || accessStart;
  assign rsp.rdata = doneFlag ? bypassData : dataArr[{reqIndex, reqWord}];

endmodule

/* logic/busArbiter.sv */
`timescale 1ns/1ps

module busArbiter (
  input  logic             clk,
  input  logic             rstN,
  input  busPkg::wbMasterT dataBus,
  input  busPkg::wbMasterT instrBus,
  output busPkg::wbSlaveT  dataRsp,
  output busPkg::wbSlaveT  instrRsp,
  output busPkg::wbMasterT wbOut,
  input  busPkg::wbSlaveT  wbIn
);

  busPkg::arbStateT state;
  busPkg::arbStateT nextState;

  // Grant moves only once the owner has dropped cyc
  always_comb
  begin
    nextState = state;
    case (state)
      busPkg::arbIdle:
        if (dataBus.cyc)
          nextState = busPkg::arbData;
        else if (instrBus.cyc)
          nextState = busPkg::arbInstr;
      busPkg::arbData:
        if (!dataBus.cyc)
          nextState = instrBus.cyc ? busPkg::arbInstr : busPkg::arbIdle;
      busPkg::arbInstr:
        if (!instrBus.cyc)
          nextState = dataBus.cyc ? busPkg::arbData : busPkg::arbIdle;
      default: nextState = busPkg::arbIdle;
    endcase
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
      state <= busPkg::arbIdle;
    else
      state <= nextState;
  end

  // Read data goes to both, ack only to the owner
  always_comb
  begin
    wbOut        = '0;
    dataRsp.dat  = wbIn.dat;
    dataRsp.ack  = 1'b0;
    instrRsp.dat = wbIn.dat;
    instrRsp.ack = 1'b0;
    case (state)
      busPkg::arbData:
      begin
        wbOut       = dataBus;
        dataRsp.ack = wbIn.ack;
      end
      busPkg::arbInstr:
      begin
        wbOut        = instrBus;
        instrRsp.ack = wbIn.ack;
      end
      default: ;
    endcase
  end

endmodule

/* logic/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
  input  logic             clk,
  input  logic             rstN,
  input  cachePkg::cpuReqT fetchReq,
  output cachePkg::cpuRspT fetchRsp,
  input  cachePkg::cpuReqT dataReq,
  output cachePkg::cpuRspT dataRsp,
  input  logic             cpEn,
  input  logic             cpWrite,
  input  cachePkg::cpOpT   cpOp,
  input  logic [31:0]      cpWdata,
  output logic [31:0]      cpRdata,
  output busPkg::wbMasterT wbOut,
  input  busPkg::wbSlaveT  wbIn
);

  logic             icacheEnable;
  logic             dcacheEnable;
  logic             invalidateI;
  logic             invalidateD;
  busPkg::wbMasterT instrWb;
  busPkg::wbMasterT dataWb;
  busPkg::wbSlaveT  instrWbRsp;
  busPkg::wbSlaveT  dataWbRsp;

  cacheControl ctrl0 (
    .clk          (clk),
    .rstN         (rstN),
    .cpEn         (cpEn),
    .cpWrite      (cpWrite),
    .cpOp         (cpOp),
    .cpWdata      (cpWdata),
    .cpRdata      (cpRdata),
    .icacheEnable (icacheEnable),
    .dcacheEnable (dcacheEnable),
    .invalidateI  (invalidateI),
    .invalidateD  (invalidateD)
  );

  instrCache icache0 (
    .clk        (clk),
    .rstN       (rstN),
    .enable     (icacheEnable),
    .invalidate (invalidateI),
    .req        (fetchReq),
    .rsp        (fetchRsp),
    .wbOut      (instrWb),
    .wbIn       (instrWbRsp)
  );

  dataCache dcache0 (
    .clk        (clk),
    .rstN       (rstN),
    .enable     (dcacheEnable),
    .invalidate (invalidateD),
    .req        (dataReq),
    .rsp        (dataRsp),
    .wbOut      (dataWb),
    .wbIn       (dataWbRsp)
  );

  // Data side has priority on the shared bus
  busArbiter arb0 (
    .clk      (clk),
    .rstN     (rstN),
    .dataBus  (dataWb),
    .instrBus (instrWb),
    .dataRsp  (dataWbRsp),
    .instrRsp (instrWbRsp),
    .wbOut    (wbOut),
    .wbIn     (wbIn)
  );

endmodule

/* sim/memSubsystem_chk.sv */
`timescale 1ns/1ps

module memSubsystemChk (
  input logic             clk,
  input logic             rstN,
  input busPkg::wbMasterT wbOut,
  input busPkg::wbSlaveT  wbIn,
  input logic             fetchValid,
  input logic             dataValid,
  input logic             instrAck,
  input logic             dataAck
);

  int failCount = 0;

  aStbNeedsCyc: assert property (@(posedge clk) disable iff (!rstN)
    wbOut.stb |-> wbOut.cyc)
  else
  begin
    failCount++;
    $error("Wishbone stb high while cyc is low");
  end

  // Master side held until the slave answers
  aStableUntilAck: assert property (@(posedge clk) disable iff (!rstN)
    (wbOut.stb && !wbIn.ack) |=> ($stable(wbOut.adr) && $stable(wbOut.we) &&
                                  $stable(wbOut.sel) && $stable(wbOut.dat)))
  else
  begin
    failCount++;
    $error("Wishbone adr, we, sel or dat changed before ack");
  end

  aCycNeedsRequest: assert property (@(posedge clk) disable iff (!rstN)
    $rose(wbOut.cyc) |-> (fetchValid || dataValid))
  else
  begin
    failCount++;
    $error("Bus cycle started with no CPU request pending");
  end

  aOneOwner: assert property (@(posedge clk) disable iff (!rstN)
    wbIn.ack |-> (instrAck ^ dataAck))
  else
  begin
    failCount++;
    $error("Slave ack steered to both masters or to none");
  end

endmodule

bind memSubsystem memSubsystemChk chk0 (
  .clk        (clk),
  .rstN       (rstN),
  .wbOut      (wbOut),
  .wbIn       (wbIn),
  .fetchValid (fetchReq.valid),
  .dataValid  (dataReq.valid),
  .instrAck   (instrWbRsp.ack),
  .dataAck    (dataWbRsp.ack)
);

/* sim/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

  // About 30 accesses, each at most 4 words of 5 cycles, with wide margin
  localparam int cycleLimit = 20000;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] wdata;
    logic [3:0]  mask;
    logic        write;
    logic        fill;
    logic [15:0] acks;
    logic [15:0] ackBase;
  } expectT;

  logic             clk;
  logic             rstN;
  cachePkg::cpuReqT fetchReq;
  cachePkg::cpuRspT fetchRsp;
  cachePkg::cpuReqT dataReq;
  cachePkg::cpuRspT dataRsp;
  logic             cpEn;
  logic             cpWrite;
  cachePkg::cpOpT   cpOp;
  logic [31:0]      cpWdata;
  logic [31:0]      cpRdata;
  busPkg::wbMasterT wbOut;
  busPkg::wbSlaveT  wbIn = '0;

  logic [31:0] mem [logic [31:0]];
  logic [1:0]  waitLeft = '0;
  logic [15:0] fetchAcks;
  logic [15:0] dataAcks;
  logic [31:0] fetchExpAdr;
  logic [31:0] dataExpAdr;
  expectT      expF;
  expectT      expD;
  logic [31:0] ctrlExp;
  logic        bothMode;
  int          errCount = 0;
  int          cycles = 0;
  int          totalErr;
  logic [31:0] lineA;
  logic [31:0] lineB;

  memSubsystem dut0 (
    .clk      (clk),
    .rstN     (rstN),
    .fetchReq (fetchReq),
    .fetchRsp (fetchRsp),
    .dataReq  (dataReq),
    .dataRsp  (dataRsp),
    .cpEn     (cpEn),
    .cpWrite  (cpWrite),
    .cpOp     (cpOp),
    .cpWdata  (cpWdata),
    .cpRdata  (cpRdata),
    .wbOut    (wbOut),
    .wbIn     (wbIn)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Untouched memory holds a word scrambled from its address
  function automatic logic [31:0] modelWord(input logic [31:0] a);
    logic [31:0] w;
    w = {a[31:2], 2'b00};
    if (mem.exists(w))
      return mem[w];
    return (w * 32'h9e37_79b9) ^ {w[15:0], w[31:16]};
  endfunction

  function automatic logic [31:0] lineBase(input logic [31:0] a);
    return a & ~32'(cachePkg::wordsPerLine * 4 - 1);
  endfunction

  function automatic logic [31:0] randLine(input logic [7:0] region);
    logic [31:0] r;
    r = $urandom;
    return {region, 12'h000, r[7:0], 4'h0};
  endfunction

  // Slave with 0 to 3 wait states before each ack
  always @(posedge clk)
  begin
    logic [31:0] w;
    if (!rstN)
      wbIn <= '0;
    else if (wbIn.ack)
      wbIn.ack <= 1'b0;
    else if (wbOut.cyc && wbOut.stb)
    begin
      if (waitLeft == 2'd0)
      begin
        if (wbOut.we)
        begin
          w = modelWord(wbOut.adr);
          for (int b = 0; b < 4; b++)
            if (wbOut.sel[b])
              w[8*b +: 8] = wbOut.dat[8*b +: 8];
          mem[{wbOut.adr[31:2], 2'b00}] = w;
        end
        wbIn.ack <= 1'b1;
        wbIn.dat <= modelWord(wbOut.adr);
        waitLeft <= 2'($urandom_range(0, 3));
      end
      else
        waitLeft <= waitLeft - 2'd1;
    end
  end

  always @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      fetchAcks <= '0;
      dataAcks  <= '0;
    end
    else
    begin
      if (dut0.instrWbRsp.ack)
        fetchAcks <= fetchAcks + 16'd1;
      if (dut0.dataWbRsp.ack)
        dataAcks <= dataAcks + 16'd1;
    end
  end

  always_comb
  begin
    fetchExpAdr = expF.fill ? lineBase(expF.addr) + (32'(fetchAcks - expF.ackBase) << 2)
                            : {expF.addr[31:2], 2'b00};
    dataExpAdr  = expD.fill ? lineBase(expD.addr) + (32'(dataAcks - expD.ackBase) << 2)
                            : {expD.addr[31:2], 2'b00};
  end

  aFetchData: assert property (@(posedge clk) disable iff (!rstN)
    (fetchReq.valid && !fetchRsp.stall) |-> fetchRsp.rdata == expF.data)
  else
  begin
    errCount++;
    $display("ERROR fetchRsp.rdata got %h expected %h", $sampled(fetchRsp.rdata),
             $sampled(expF.data));
  end

  aLoadData: assert property (@(posedge clk) disable iff (!rstN)
    (dataReq.valid && !dataReq.write && !dataRsp.stall) |-> dataRsp.rdata == expD.data)
  else
  begin
    errCount++;
    $display("ERROR dataRsp.rdata got %h expected %h", $sampled(dataRsp.rdata),
             $sampled(expD.data));
  end

  aFetchAcks: assert property (@(posedge clk) disable iff (!rstN)
    (fetchReq.valid && !fetchRsp.stall) |-> (fetchAcks - expF.ackBase) == expF.acks)
  else
  begin
    errCount++;
    $display("ERROR fetch bus words got %h expected %h",
             $sampled(fetchAcks - expF.ackBase), $sampled(expF.acks));
  end

  aDataAcks: assert property (@(posedge clk) disable iff (!rstN)
    (dataReq.valid && !dataRsp.stall) |-> (dataAcks - expD.ackBase) == expD.acks)
  else
  begin
    errCount++;
    $display("ERROR data bus words got %h expected %h",
             $sampled(dataAcks - expD.ackBase), $sampled(expD.acks));
  end

  // Hits answer in the cycle they are presented
  aFetchHit: assert property (@(posedge clk) disable iff (!rstN)
    (fetchReq.valid && expF.acks == 16'd0) |-> !fetchRsp.stall)
  else
  begin
    errCount++;
    $display("ERROR fetchRsp.stall on hit got %h expected 0", $sampled(fetchRsp.stall));
  end

  aLoadHit: assert property (@(posedge clk) disable iff (!rstN)
    (dataReq.valid && expD.acks == 16'd0) |-> !dataRsp.stall)
  else
  begin
    errCount++;
    $display("ERROR dataRsp.stall on hit got %h expected 0", $sampled(dataRsp.stall));
  end

  aFetchAdr: assert property (@(posedge clk) disable iff (!rstN)
    dut0.instrWbRsp.ack |-> (wbOut.adr == fetchExpAdr && !wbOut.we))
  else
  begin
    errCount++;
    $display("ERROR wbOut.adr for fetch got %h expected %h", $sampled(wbOut.adr),
             $sampled(fetchExpAdr));
  end

  aDataAdr: assert property (@(posedge clk) disable iff (!rstN)
    dut0.dataWbRsp.ack |-> (wbOut.adr == dataExpAdr && wbOut.we == expD.write))
  else
  begin
    errCount++;
    $display("ERROR wbOut.adr for data got %h expected %h", $sampled(wbOut.adr),
             $sampled(dataExpAdr));
  end

  aStoreBus: assert property (@(posedge clk) disable iff (!rstN)
    (dut0.dataWbRsp.ack && wbOut.we) |-> (wbOut.sel == expD.mask && wbOut.dat == expD.wdata))
  else
  begin
    errCount++;
    $display("ERROR wbOut.sel/dat got %h/%h expected %h/%h", $sampled(wbOut.sel),
             $sampled(wbOut.dat), $sampled(expD.mask), $sampled(expD.wdata));
  end

  // Data side owns the bus until its whole fill is done
  aDataFirst: assert property (@(posedge clk) disable iff (!rstN)
    (bothMode && dut0.instrWbRsp.ack) |-> (dataAcks - expD.ackBase) == expD.acks)
  else
  begin
    errCount++;
    $display("Instruction fill got the bus before the data fill finished");
  end

  aCtrlRead: assert property (@(posedge clk) disable iff (!rstN)
    (cpEn && cpWrite && cpOp == cachePkg::cpControl) |=> cpRdata == ctrlExp)
  else
  begin
    errCount++;
    $display("ERROR cpRdata got %h expected %h", $sampled(cpRdata), $sampled(ctrlExp));
  end

  task automatic access(input logic isData, input logic write, input logic [31:0] addr,
                        input logic [31:0] wdata, input logic [3:0] mask,
                        input logic [15:0] acks, input logic fill);
    cachePkg::cpuReqT r;
    expectT           e;
    r = '{valid: 1'b1, write: write, addr: addr, wdata: wdata, byteMask: mask};
    e = '{addr: addr, data: modelWord(addr), wdata: wdata, mask: mask, write: write,
          fill: fill, acks: acks, ackBase: isData ? dataAcks : fetchAcks};
    @(posedge clk);
    if (isData)
    begin
      dataReq <= r;
      expD    <= e;
    end
    else
    begin
      fetchReq <= r;
      expF     <= e;
    end
    do
      @(posedge clk);
    while (isData ? dataRsp.stall : fetchRsp.stall);
    if (isData)
      dataReq.valid <= 1'b0;
    else
      fetchReq.valid <= 1'b0;
  endtask

  task automatic coproc(input cachePkg::cpOpT op, input logic [31:0] wdata);
    @(posedge clk);
    cpEn    <= 1'b1;
    cpWrite <= 1'b1;
    cpOp    <= op;
    cpWdata <= wdata;
    if (op == cachePkg::cpControl)
      ctrlExp <= wdata;
    @(posedge clk);
    cpEn    <= 1'b0;
    cpWrite <= 1'b0;
  endtask

  task automatic report(input int num, input string name);
    $display("Test %0d %s finished, %0d errors so far", num, name, errCount);
  endtask

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("Timeout after %0d cycles, a request never completed", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'hcff1_5322));
    rstN     = 1'b0;
    fetchReq = '0;
    dataReq  = '0;
    cpEn     = 1'b0;
    cpWrite  = 1'b0;
    cpOp     = cachePkg::cpControl;
    cpWdata  = '0;
    expF     = '0;
    expD     = '0;
    ctrlExp  = '0;
    bothMode = 1'b0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;

    lineA = randLine(8'h10) + 32'h8;
    lineB = randLine(8'h11) + 32'h4;
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd1, 1'b0);
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd1, 1'b0);
    access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd1, 1'b0);
    access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd1, 1'b0);
    report(1, "disabled caches");

    coproc(cachePkg::cpControl, 32'h1 << cachePkg::icacheEnableBit);
    lineA = randLine(8'h20) + 32'h4;
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd4, 1'b1);
    access(1'b0, 1'b0, lineA + 32'h4, '0, 4'hf, 16'd0, 1'b0);
    access(1'b0, 1'b0, lineBase(lineA), '0, 4'hf, 16'd0, 1'b0);
    report(2, "instruction cache fill");

    coproc(cachePkg::cpControl, (32'h1 << cachePkg::icacheEnableBit) |
                                (32'h1 << cachePkg::dcacheEnableBit));
    lineA = randLine(8'h30);
    access(1'b1, 1'b0, lineA, '0, 4'hf, 16'd4, 1'b1);
    access(1'b1, 1'b1, lineA + 32'h4, $urandom, 4'($urandom_range(1, 15)), 16'd1, 1'b0);
    access(1'b1, 1'b0, lineA + 32'h4, '0, 4'hf, 16'd0, 1'b0);
    // Same index, other tag, so the store misses
    lineB = lineA + 32'h100;
    access(1'b1, 1'b1, lineB + 32'h8, $urandom, 4'($urandom_range(1, 15)), 16'd1, 1'b0);
    access(1'b1, 1'b0, lineB + 32'h8, '0, 4'hf, 16'd4, 1'b1);
    report(3, "data cache write-through");

    lineA = randLine(8'h40);
    lineB = randLine(8'h41) + 32'hc;
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd4, 1'b1);
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd0, 1'b0);
    coproc(cachePkg::cpInvalidateI, '0);
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd4, 1'b1);
    access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd4, 1'b1);
    access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd0, 1'b0);
    coproc(cachePkg::cpInvalidateD, '0);
    access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd4, 1'b1);
    report(4, "invalidate");

    lineA = randLine(8'h50) + 32'h4;
    lineB = randLine(8'h51) + 32'h8;
    bothMode <= 1'b1;
    fork
      access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd4, 1'b1);
      access(1'b1, 1'b0, lineB, '0, 4'hf, 16'd4, 1'b1);
    join
    bothMode <= 1'b0;
    report(5, "arbitration");

    coproc(cachePkg::cpControl, '0);
    lineA = randLine(8'h60);
    access(1'b1, 1'b1, lineA, $urandom, 4'($urandom_range(1, 15)), 16'd1, 1'b0);
    access(1'b1, 1'b0, lineA, '0, 4'hf, 16'd1, 1'b0);
    access(1'b0, 1'b0, lineA, '0, 4'hf, 16'd1, 1'b0);
    repeat (4) @(posedge clk);
    report(6, "bus protocol");

    totalErr = errCount + dut0.chk0.failCount;
    $display("Tests run 6, failed checks %0d", totalErr);
    if (totalErr == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

/* filelist.f */
logic/cachePkg.sv
logic/busPkg.sv
logic/cacheControl.sv
logic/instrCache.sv
logic/dataCache.sv
logic/busArbiter.sv
logic/memSubsystem.sv
sim/memSubsystem_chk.sv
sim/memSubsystemTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = memSubsystemTb
FILELIST  = filelist.f
RUNARGS   = +verilator+error+limit+1000

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP) $(RUNARGS)); echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
